//--- logic/freq_meter_pkg.sv
//**************************************************
// widths and record layout shared by the meter
// a record body is a timestamp or a lost-edge count
// chan_w must cover num_chan
//**************************************************
`default_nettype none

package freq_meter_pkg;

    localparam int ts_w     = 32;   // timestamp counter and result width
    localparam int lost_w   = 16;   // saturating lost-edge count
    localparam int num_chan = 2;    // wave inputs
    localparam int chan_w   = 1;    // channel index width

    // flat record word, msb first: chan, rise, drop, body
    localparam int rec_w = ts_w + 1 + 1 + chan_w;

    // record body, decoded by the drop flag that travels beside it
    typedef union packed {
        logic [ts_w-1:0]                      stamp;  // edge record
        logic [ts_w/lost_w-1:0][lost_w-1:0]   drop;   // drop[0] is the count, rest pad
    } rec_body_u;

endpackage

`default_nettype wire

//--- logic/wave_edge_stamper.sv
//**************************************************
// stamps wave edges against a free running counter
// wave_in is async, two flop sync, no glitch filter
// edges arriving while the record port stalls are lost
//**************************************************
`timescale 1ns/1ps
`default_nettype none

module wave_edge_stamper (
    input  logic                                pll_clk,
    input  logic                                sys_rst_n,
    input  logic [freq_meter_pkg::num_chan-1:0] wave_in,
    input  logic                                rec_ready,
    output logic                                rec_valid,
    output logic [freq_meter_pkg::chan_w-1:0]   rec_chan,
    output logic                                rec_rise,
    output logic                                rec_drop,
    output freq_meter_pkg::rec_body_u           rec_body
);
    import freq_meter_pkg::*;

    logic [ts_w-1:0]     ts_cnt;               // wraps, consumer diffs mod 2^32
    logic [num_chan-1:0] sync1;
    logic [num_chan-1:0] sync2;
    logic [num_chan-1:0] hist;                 // previous synced level
    logic [num_chan-1:0] edge_det;
    logic [num_chan-1:0] pend_vld;             // one held edge per channel
    logic [num_chan-1:0] pend_rise;
    logic [ts_w-1:0]     pend_ts [num_chan];
    logic [lost_w-1:0]   lost_cnt [num_chan];
    logic                out_free;             // output reg can take a record
    logic                sel_vld;
    logic [chan_w-1:0]   sel_chan;
    logic                sel_rise;
    logic                sel_drop;
    rec_body_u           sel_body;
    logic [num_chan-1:0] take_drop;
    logic [num_chan-1:0] take_pend;
    logic [num_chan-1:0] take_new;
    logic [num_chan-1:0] lose;

    function automatic logic [lost_w-1:0] sat_add(input logic [lost_w-1:0] a,
                                                  input logic [1:0]        b);
        logic [lost_w:0] sum;
        sum = {1'b0, a} + b;
        return sum[lost_w] ? '1 : sum[lost_w-1:0];  // stick at max
    endfunction

    assign edge_det = sync2 ^ hist;
    assign out_free = !rec_valid || rec_ready;

    always_ff @(posedge pll_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            ts_cnt <= '0;
            sync1  <= '0;
            sync2  <= '0;
            hist   <= '0;
        end else begin
            ts_cnt <= ts_cnt + 1'b1;
            sync1  <= wave_in;
            sync2  <= sync1;
            hist   <= sync2;
        end
    end

    // priority: drop records, then held edges, then fresh edges, low channel first
    always_comb begin
        sel_vld   = 1'b0;
        sel_chan  = '0;
        sel_rise  = 1'b0;
        sel_drop  = 1'b0;
        sel_body  = '0;
        take_drop = '0;
        take_pend = '0;
        take_new  = '0;
        for (int c = 0; c < num_chan; c++) begin
            if (out_free && !sel_vld && lost_cnt[c] != '0) begin
                sel_vld          = 1'b1;
                sel_chan         = chan_w'(c);
                sel_drop         = 1'b1;
                sel_body.drop[0] = lost_cnt[c];
                take_drop[c]     = 1'b1;
            end
        end
        for (int c = 0; c < num_chan; c++) begin
            if (out_free && !sel_vld && pend_vld[c]) begin
                sel_vld        = 1'b1;
                sel_chan       = chan_w'(c);
                sel_rise       = pend_rise[c];
                sel_body.stamp = pend_ts[c];
                take_pend[c]   = 1'b1;
            end
        end
        for (int c = 0; c < num_chan; c++) begin
            if (out_free && !sel_vld && edge_det[c] && lost_cnt[c] == '0) begin
                sel_vld        = 1'b1;
                sel_chan       = chan_w'(c);
                sel_rise       = sync2[c];     // new level high means rising
                sel_body.stamp = ts_cnt;
                take_new[c]    = 1'b1;
            end
        end
        // stalled, still owing a drop record, or slot busy
        for (int c = 0; c < num_chan; c++) begin
            lose[c] = edge_det[c] && (!out_free || (lost_cnt[c] != '0 && !take_drop[c]) ||
                                      (pend_vld[c] && !take_pend[c]));
        end
    end

    always_ff @(posedge pll_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            rec_valid <= 1'b0;
            pend_vld  <= '0;
            for (int c = 0; c < num_chan; c++) begin
                lost_cnt[c] <= '0;
            end
        end else begin
            if (out_free) begin
                rec_valid <= sel_vld;
            end
            for (int c = 0; c < num_chan; c++) begin
                if (lose[c]) begin
                    // a held edge goes too, keeps per channel order behind the drop
                    lost_cnt[c] <= sat_add(lost_cnt[c], pend_vld[c] ? 2'd2 : 2'd1);
                    pend_vld[c] <= 1'b0;
                end else begin
                    if (take_drop[c]) begin
                        lost_cnt[c] <= '0;
                    end
                    if (edge_det[c] && !take_new[c]) begin
                        pend_vld[c] <= 1'b1;
                    end else if (take_pend[c]) begin
                        pend_vld[c] <= 1'b0;
                    end
                end
            end
        end
    end

    always_ff @(posedge pll_clk) begin
        for (int c = 0; c < num_chan; c++) begin
            if (edge_det[c] && !take_new[c] && !lose[c]) begin
                pend_rise[c] <= sync2[c];
                pend_ts[c]   <= ts_cnt;        // stamp at detection, not issue
            end
        end
        if (out_free && sel_vld) begin
            rec_chan <= sel_chan;
            rec_rise <= sel_rise;
            rec_drop <= sel_drop;
            rec_body <= sel_body;
        end
    end

    // fifo relies on the record holding still until taken
    a_rec_hold: assert property (@(posedge pll_clk) disable iff (!sys_rst_n)
        rec_valid && !rec_ready |=> rec_valid && $stable(rec_chan) && $stable(rec_rise) &&
                                    $stable(rec_drop) && $stable(rec_body));

endmodule

`default_nettype wire

//--- logic/edge_fifo.sv
//**************************************************
// valid/ready fifo, registered fall-through output
// FIFO_DEPTH must be a power of two, at least 2
//**************************************************
`timescale 1ns/1ps
`default_nettype none

module edge_fifo #(
    parameter int FIFO_DEPTH = 8
) (
    input  logic                             pll_clk,
    input  logic                             sys_rst_n,
    input  logic                             in_valid,
    input  logic [freq_meter_pkg::rec_w-1:0] in_word,
    output logic                             in_ready,
    output logic                             out_valid,
    output logic [freq_meter_pkg::rec_w-1:0] out_word,
    input  logic                             out_ready
);
    import freq_meter_pkg::*;

    localparam int IDX_W = $clog2(FIFO_DEPTH);

    logic [rec_w-1:0] mem [FIFO_DEPTH];
    logic [IDX_W:0]   wr_ptr;                  // extra msb tells full from empty
    logic [IDX_W:0]   rd_ptr;
    logic             full;
    logic             empty;
    logic             wr_en;
    logic             load_out;                // move head into output reg

    assign empty    = wr_ptr == rd_ptr;
    assign full     = (wr_ptr[IDX_W] != rd_ptr[IDX_W]) &&
                      (wr_ptr[IDX_W-1:0] == rd_ptr[IDX_W-1:0]);
    assign in_ready = !full;
    assign wr_en    = in_valid && !full;
    assign load_out = !empty && (!out_valid || out_ready);

    always_ff @(posedge pll_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            out_valid <= 1'b0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (load_out) begin
                rd_ptr    <= rd_ptr + 1'b1;
                out_valid <= 1'b1;
            end else if (out_ready) begin
                out_valid <= 1'b0;         // taken, nothing behind it
            end
        end
    end

    always_ff @(posedge pll_clk) begin
        if (wr_en) begin
            mem[wr_ptr[IDX_W-1:0]] <= in_word;
        end
        if (load_out) begin
            out_word <= mem[rd_ptr[IDX_W-1:0]];  // one cycle behind the write
        end
    end

    // write refused while full must stay offered, so nothing slips past
    a_no_overrun: assert property (@(posedge pll_clk) disable iff (!sys_rst_n)
        in_valid && !in_ready |=> in_valid && $stable(in_word));

    // head word held until the meter reads it
    a_no_underrun: assert property (@(posedge pll_clk) disable iff (!sys_rst_n)
        out_valid && !out_ready |=> out_valid && $stable(out_word));

endmodule

`default_nettype wire

//--- logic/period_meter.sv
//**************************************************
// window of NUM_CYCLES periods per channel, 1..255
// results in raw ticks, stamp diffs taken mod 2^32
// one result held at a time, input stalls meanwhile
//**************************************************
`timescale 1ns/1ps
`default_nettype none

module period_meter #(
    parameter int NUM_CYCLES = 4
) (
    input  logic                             pll_clk,
    input  logic                             sys_rst_n,
    input  logic                             in_valid,
    input  logic [freq_meter_pkg::rec_w-1:0] in_word,
    output logic                             in_ready,
    output logic                             meas_valid,
    output logic [freq_meter_pkg::chan_w-1:0] meas_chan,
    output logic [freq_meter_pkg::ts_w-1:0]  period_total,
    output logic [freq_meter_pkg::ts_w-1:0]  high_total,
    input  logic                             meas_ready
);
    import freq_meter_pkg::*;

    localparam int CNT_W = 8;                  // rises counted inside a window

    logic [chan_w-1:0]   in_chan;
    logic                in_rise;
    logic                in_drop;
    rec_body_u           in_body;
    logic [ts_w-1:0]     in_stamp;
    logic                acc;                  // record taken this cycle
    logic                win_done;             // closing rise of a window
    logic [num_chan-1:0] armed;
    logic [CNT_W-1:0]    rise_cnt [num_chan];
    logic [ts_w-1:0]     start_ts [num_chan];
    logic [ts_w-1:0]     rise_ts  [num_chan];  // last rise, for high time
    logic [ts_w-1:0]     high_acc [num_chan];

    // flat word is {chan, rise, drop, body}
    assign in_chan  = in_word[rec_w-1 -: chan_w];
    assign in_rise  = in_word[ts_w+1];
    assign in_drop  = in_word[ts_w];
    assign in_body  = in_word[ts_w-1:0];
    assign in_stamp = in_body.stamp;

    assign in_ready = !meas_valid;             // hold off while a result waits
    assign acc      = in_valid && in_ready;
    assign win_done = acc && !in_drop && in_rise && armed[in_chan] &&
                      rise_cnt[in_chan] == CNT_W'(NUM_CYCLES - 1);

    always_ff @(posedge pll_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            meas_valid <= 1'b0;
            armed      <= '0;
            for (int c = 0; c < num_chan; c++) begin
                rise_cnt[c] <= '0;
            end
        end else begin
            if (meas_valid && meas_ready) begin
                meas_valid <= 1'b0;
            end else if (win_done) begin
                meas_valid <= 1'b1;
            end
            if (acc) begin
                if (in_drop) begin
                    armed[in_chan] <= 1'b0;          // edges missing, start over
                end else if (in_rise) begin
                    armed[in_chan] <= 1'b1;
                    if (!armed[in_chan] || win_done) begin
                        rise_cnt[in_chan] <= '0;
                    end else begin
                        rise_cnt[in_chan] <= rise_cnt[in_chan] + 1'b1;
                    end
                end
            end
        end
    end

    always_ff @(posedge pll_clk) begin
        if (acc && !in_drop) begin
            if (in_rise) begin
                rise_ts[in_chan] <= in_stamp;
                // closing rise opens the next window, windows back to back
                if (!armed[in_chan] || win_done) begin
                    start_ts[in_chan] <= in_stamp;
                    high_acc[in_chan] <= '0;
                end
            end else if (armed[in_chan]) begin
                high_acc[in_chan] <= high_acc[in_chan] + (in_stamp - rise_ts[in_chan]);
            end
        end
        if (win_done) begin
            meas_chan    <= in_chan;
            period_total <= in_stamp - start_ts[in_chan];  // wraps cleanly
            high_total   <= high_acc[in_chan];
        end
    end

    a_meas_hold: assert property (@(posedge pll_clk) disable iff (!sys_rst_n)
        meas_valid && !meas_ready |=> meas_valid && $stable(meas_chan) &&
                                      $stable(period_total) && $stable(high_total));

    a_high_le_period: assert property (@(posedge pll_clk) disable iff (!sys_rst_n)
        meas_valid |-> high_total <= period_total);

    // stamper only sends a drop record once it has lost something
    a_drop_nonzero: assert property (@(posedge pll_clk) disable iff (!sys_rst_n)
        acc && in_drop |-> in_body.drop[0] != '0);

endmodule

`default_nettype wire

//--- logic/square_wave_freq.sv
//**************************************************
// frequency and duty meter for two square waves
// single clock domain, results in pll_clk ticks
//**************************************************
`timescale 1ns/1ps
`default_nettype none

module square_wave_freq #(
    parameter int NUM_CYCLES = 4,              // periods per window, 1..255
    parameter int FIFO_DEPTH = 8               // power of two
) (
    input  logic                                pll_clk,
    input  logic                                sys_rst_n,
    input  logic [freq_meter_pkg::num_chan-1:0] wave_in,
    input  logic                                meas_ready,
    output logic                                meas_valid,
    output logic [freq_meter_pkg::chan_w-1:0]   meas_chan,
    output logic [freq_meter_pkg::ts_w-1:0]     period_total,
    output logic [freq_meter_pkg::ts_w-1:0]     high_total
);
    import freq_meter_pkg::*;

    logic              rec_valid;
    logic              rec_ready;
    logic [chan_w-1:0] rec_chan;
    logic              rec_rise;
    logic              rec_drop;
    rec_body_u         rec_body;
    logic [rec_w-1:0]  rec_word;
    logic              fifo_valid;
    logic              fifo_ready;
    logic [rec_w-1:0]  fifo_word;

    assign rec_word = {rec_chan, rec_rise, rec_drop, rec_body};  // meter unpacks same order

    wave_edge_stamper i_stamper (
        .pll_clk   (pll_clk),
        .sys_rst_n (sys_rst_n),
        .wave_in   (wave_in),
        .rec_ready (rec_ready),
        .rec_valid (rec_valid),
        .rec_chan  (rec_chan),
        .rec_rise  (rec_rise),
        .rec_drop  (rec_drop),
        .rec_body  (rec_body)
    );

    edge_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) i_fifo (
        .pll_clk   (pll_clk),
        .sys_rst_n (sys_rst_n),
        .in_valid  (rec_valid),
        .in_word   (rec_word),
        .in_ready  (rec_ready),
        .out_valid (fifo_valid),
        .out_word  (fifo_word),
        .out_ready (fifo_ready)
    );

    period_meter #(.NUM_CYCLES(NUM_CYCLES)) i_meter (
        .pll_clk      (pll_clk),
        .sys_rst_n    (sys_rst_n),
        .in_valid     (fifo_valid),
        .in_word      (fifo_word),
        .in_ready     (fifo_ready),
        .meas_valid   (meas_valid),
        .meas_chan    (meas_chan),
        .period_total (period_total),
        .high_total   (high_total),
        .meas_ready   (meas_ready)
    );

endmodule

`default_nettype wire

//--- verif/tb_square_wave_freq.sv
//**************************************************
// directed testbench, NUM_CYCLES fixed at 4
// expects period 4*(H+L) and high time 4*H in ticks
// wave edges land on pll_clk edges, so stamps are exact
//**************************************************
`timescale 1ns/1ps
`default_nettype none

module tb_square_wave_freq;

    localparam int num_cycles     = 4;
    localparam int max_period     = 128;                 // random H and L up to 64 each
    localparam int result_timeout = 2 * num_cycles * max_period + 200;  // cycles
    localparam int test_windows   = 50;                  // rough sum over all tests
    localparam longint watchdog_ns =
        longint'(test_windows) * 2 * num_cycles * max_period * 100 + 100000;

    logic        pll_clk    = 1'b0;
    logic        sys_rst_n  = 1'b0;
    logic [1:0]  wave_in    = 2'b00;
    logic        meas_ready = 1'b0;
    logic        meas_valid;
    logic [0:0]  meas_chan;
    logic [31:0] period_total;
    logic [31:0] high_total;

    int          hi_cnt [2] = '{0, 0};                   // 0 parks the channel low
    int          lo_cnt [2] = '{0, 0};
    int          run_cnt [2] = '{0, 0};
    int          chk_cnt = 0;
    int          err_cnt = 0;
    logic [31:0] lfsr_state = 32'h2dff662e;

    square_wave_freq #(.NUM_CYCLES(num_cycles), .FIFO_DEPTH(8)) i_dut (
        .pll_clk      (pll_clk),
        .sys_rst_n    (sys_rst_n),
        .wave_in      (wave_in),
        .meas_ready   (meas_ready),
        .meas_valid   (meas_valid),
        .meas_chan    (meas_chan),
        .period_total (period_total),
        .high_total   (high_total)
    );

    always #50 pll_clk = ~pll_clk;                       // 100 ns period

    // wave driver, level held hi_cnt or lo_cnt whole cycles
    always @(posedge pll_clk) begin
        for (int c = 0; c < 2; c++) begin
            if (hi_cnt[c] == 0) begin
                wave_in[c] <= 1'b0;
                run_cnt[c] <= 0;
            end else if (run_cnt[c] + 1 >= (wave_in[c] ? hi_cnt[c] : lo_cnt[c])) begin
                wave_in[c] <= !wave_in[c];
                run_cnt[c] <= 0;
            end else begin
                run_cnt[c] <= run_cnt[c] + 1;
            end
        end
    end

    initial begin
        #(watchdog_ns);
        $display("watchdog expired after %0d ns, tests did not finish", watchdog_ns);
        $display("** FAIL **");
        $finish;
    end

    // galois form, x^32+x^22+x^2+x+1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    function automatic int draw_bits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);      // one step per bit
            v = (v << 1) | int'(lfsr_state[0]);
        end
        return v;
    endfunction

    task automatic compare_value(input string name, input int exp, input int act);
        chk_cnt++;
        assert (exp == act) else begin
            $display("ERR t=%0t %s expected %0d got %0d", $time, name, exp, act);
            err_cnt++;
        end
    endtask

    task automatic check_window(input int h, input int l, input int per, input int hi);
        compare_value("period_total", num_cycles * (h + l), per);
        compare_value("high_total", num_cycles * h, hi);
    endtask

    task automatic set_waves(input int h0, input int l0, input int h1, input int l1);
        @(posedge pll_clk);
        hi_cnt[0] <= h0;
        lo_cnt[0] <= l0;
        hi_cnt[1] <= h1;
        lo_cnt[1] <= l1;
    endtask

    // outputs sampled at the edge, so pre-edge values, handshake seen as it happens
    task automatic next_result(output bit got, output int ch, output int per, output int hi);
        int waited;
        got = 1'b0;
        ch = 0;
        per = 0;
        hi = 0;
        waited = 0;
        while (!got && waited < result_timeout) begin
            @(posedge pll_clk);
            waited++;
            if (meas_valid && meas_ready) begin
                got = 1'b1;
                ch = int'(meas_chan);
                per = int'(period_total);
                hi = int'(high_total);
            end
        end
        assert (got) else begin
            $display("no result arrived within %0d cycles at %0t", result_timeout, $time);
            err_cnt++;
        end
    endtask

    // other channel's leftovers are skipped
    task automatic wait_chan_result(input int chan, output bit got, output int per,
                                    output int hi);
        int ch;
        int tries;
        got = 1'b1;
        ch = -1;
        tries = 0;
        while (got && ch != chan && tries < 8) begin
            next_result(got, ch, per, hi);
            tries++;
        end
        if (got && ch != chan) begin
            $display("no result for channel %0d among %0d results at %0t", chan, tries, $time);
            err_cnt++;
            got = 1'b0;
        end
    endtask

    // meas_ready already low, waits for a result to sit on the port
    task automatic wait_valid_held(output bit seen);
        int waited;
        waited = 0;
        @(posedge pll_clk);                          // skip the edge of the last transfer
        while (!meas_valid && waited < result_timeout) begin
            @(posedge pll_clk);
            waited++;
        end
        seen = meas_valid;
        assert (seen) else begin
            $display("no held result appeared within %0d cycles", result_timeout);
            err_cnt++;
        end
    endtask

    task automatic report_test(input string name, input int c0, input int e0);
        $display("%s: %0d checks, %0d errors", name, chk_cnt - c0, err_cnt - e0);
    endtask

    task automatic test_steady_ch0();
        int  c0;
        int  e0;
        bit  got;
        int  ch;
        int  per;
        int  hi;
        c0 = chk_cnt;
        e0 = err_cnt;
        set_waves(3, 5, 0, 0);
        next_result(got, ch, per, hi);               // first window dropped
        for (int i = 0; i < 3 && got; i++) begin
            next_result(got, ch, per, hi);
            if (got) begin
                compare_value("meas_chan", 0, ch);
                check_window(3, 5, per, hi);
            end
        end
        report_test("steady_ch0", c0, e0);
    endtask

    task automatic test_two_channels();
        int c0;
        int e0;
        int h [2];
        int l [2];
        int seen [2];
        int done [2];
        int n;
        bit got;
        int ch;
        int per;
        int hi;
        c0 = chk_cnt;
        e0 = err_cnt;
        h = '{3, 4};                                 // lcm 24, edges coincide often
        l = '{5, 2};
        seen = '{0, 0};
        done = '{0, 0};
        n = 0;
        got = 1'b1;
        set_waves(h[0], l[0], h[1], l[1]);
        while (got && n < 40 && (done[0] < 3 || done[1] < 3)) begin
            next_result(got, ch, per, hi);
            n++;
            if (got) begin
                if (seen[ch] >= 2 && done[ch] < 3) begin
                    check_window(h[ch], l[ch], per, hi);
                    done[ch]++;
                end
                seen[ch]++;
            end
        end
        assert (done[0] >= 3 && done[1] >= 3) else begin
            $display("too few results per channel, got %0d and %0d", done[0], done[1]);
            err_cnt++;
        end
        report_test("two_channels", c0, e0);
    endtask

    task automatic test_random_duty();
        int c0;
        int e0;
        int h;
        int l;
        bit got;
        int per;
        int hi;
        c0 = chk_cnt;
        e0 = err_cnt;
        for (int s = 0; s < 5; s++) begin
            h = 1 + draw_bits(6);
            l = 1 + draw_bits(6);
            if (h + l < 3) begin
                l = 2;                               // keep edge rate under drain rate
            end
            set_waves(h, l, 0, 0);
            wait_chan_result(0, got, per, hi);       // two windows to settle
            wait_chan_result(0, got, per, hi);
            for (int i = 0; i < 2 && got; i++) begin
                wait_chan_result(0, got, per, hi);
                if (got) begin
                    check_window(h, l, per, hi);
                end
            end
        end
        report_test("random_duty", c0, e0);
    endtask

    task automatic test_backpressure();
        int c0;
        int e0;
        bit got;
        int ch;
        int per;
        int hi;
        int held_ch;
        int held_per;
        int held_hi;
        c0 = chk_cnt;
        e0 = err_cnt;
        set_waves(10, 10, 0, 0);                     // one edge per 10 cycles, fifo keeps up
        wait_chan_result(0, got, per, hi);
        wait_chan_result(0, got, per, hi);
        meas_ready <= 1'b0;
        wait_valid_held(got);
        if (got) begin
            held_ch = int'(meas_chan);
            held_per = int'(period_total);
            held_hi = int'(high_total);
            repeat (12) begin
                @(posedge pll_clk);
                compare_value("meas_valid", 1, int'(meas_valid));
                compare_value("meas_chan", held_ch, int'(meas_chan));
                compare_value("period_total", held_per, int'(period_total));
                compare_value("high_total", held_hi, int'(high_total));
            end
        end
        meas_ready <= 1'b1;
        next_result(got, ch, per, hi);
        if (got) begin
            compare_value("meas_chan", held_ch, ch);
            compare_value("period_total", held_per, per);
            compare_value("high_total", held_hi, hi);
            check_window(10, 10, per, hi);
        end
        wait_chan_result(0, got, per, hi);           // flow resumes afterwards
        if (got) begin
            check_window(10, 10, per, hi);
        end
        report_test("backpressure", c0, e0);
    endtask

    task automatic test_overflow();
        int c0;
        int e0;
        bit got;
        int per;
        int hi;
        c0 = chk_cnt;
        e0 = err_cnt;
        set_waves(1, 1, 0, 0);                       // one edge every cycle
        wait_chan_result(0, got, per, hi);
        wait_chan_result(0, got, per, hi);
        meas_ready <= 1'b0;
        wait_valid_held(got);
        repeat (60) @(posedge pll_clk);              // fifo fills, stamper drops edges
        meas_ready <= 1'b1;
        for (int i = 0; i < 5 && got; i++) begin
            wait_chan_result(0, got, per, hi);
            if (got) begin
                compare_value("period_total mod (H+L)", 0, per % 2);
                if (i >= 2) begin
                    check_window(1, 1, per, hi);     // after the drop record
                end
            end
        end
        report_test("overflow", c0, e0);
    endtask

    initial begin
        repeat (3) @(posedge pll_clk);
        sys_rst_n <= 1'b1;
        meas_ready <= 1'b1;
        test_steady_ch0();
        test_two_channels();
        test_random_duty();
        test_backpressure();
        test_overflow();
        $display("total: %0d checks, %0d errors", chk_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- all.f
logic/freq_meter_pkg.sv
logic/wave_edge_stamper.sv
logic/edge_fifo.sv
logic/period_meter.sv
logic/square_wave_freq.sv
verif/tb_square_wave_freq.sv

//--- run_sim.sh
#!/bin/sh
# build the frequency meter testbench with Verilator, run it, look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f all.f \
    --top-module tb_square_wave_freq -o sim_tb
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/sim_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q -F '** PASS **'; then
    exit 0
fi
exit 1
